//--- fcvt_pkg.sv
`default_nettype none

package fcvt_pkg;

    typedef enum logic [1:0] {
        FP32 = 2'd0,
        FP16 = 2'd1
    } fp_fmt_e;

    // RISC-V frm encoding
    typedef enum logic [2:0] {
        RNE = 3'd0,
        RTZ = 3'd1,
        RDN = 3'd2,
        RUP = 3'd3,
        RMM = 3'd4
    } roundmode_e;

    typedef struct packed {
        logic NV;
        logic DZ;
        logic OF;
        logic UF;
        logic NX;
    } fflags_t;

    typedef enum logic [1:0] {
        OP_F2I = 2'd0,
        OP_I2F = 2'd1,
        OP_F2H = 2'd2
    } fcvt_op_e;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] mant;
    } fp32_t;

    // one source word, read as float fields or as a plain integer
    typedef union packed {
        fp32_t       fp;
        logic [31:0] raw;
    } fp_word_u;

    function automatic int unsigned exp_bits(fp_fmt_e fmt);
        return (fmt == FP16) ? 5 : 8;
    endfunction

    function automatic int unsigned man_bits(fp_fmt_e fmt);
        return (fmt == FP16) ? 10 : 23;
    endfunction

endpackage

`default_nettype wire

//--- fcvt_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fcvt_if;
    logic [31:0]          src;
    fcvt_pkg::roundmode_e rm;
    logic                 uext;    // treat the integer side as unsigned
    logic                 is_nan;
    logic [31:0]          dest;
    fcvt_pkg::fflags_t    flags;

    modport conv (input src, rm, uext, is_nan, output dest, flags);

    modport ctrl (output src, rm, uext, is_nan, input dest, flags);
endinterface

`default_nettype wire

//--- fp_rounding.sv
`timescale 1ns/1ps
`default_nettype none

module fp_rounding #(
    parameter int WIDTH = 23
) (
    input  wire [WIDTH-1:0]           mant_i,
    input  wire                       guard_i,
    input  wire                       sticky_i,
    input  wire                       sign_i,
    input  wire fcvt_pkg::roundmode_e rm_i,
    output logic [WIDTH-1:0]          mant_o,
    output logic                      inexact_o,
    output logic                      cout_o,
    output logic                      up_o
);
    logic up;

    always_comb begin
        case (rm_i)
            fcvt_pkg::RNE: up = guard_i & (sticky_i | mant_i[0]);   // tie goes to even lsb
            fcvt_pkg::RTZ: up = 1'b0;
            fcvt_pkg::RDN: up = (guard_i | sticky_i) & sign_i;
            fcvt_pkg::RUP: up = (guard_i | sticky_i) & ~sign_i;
            fcvt_pkg::RMM: up = guard_i;
            default:       up = 1'b0;
        endcase
    end

    assign {cout_o, mant_o} = {1'b0, mant_i} + up;
    assign inexact_o = guard_i | sticky_i;
    assign up_o = up;
endmodule

`default_nettype wire

//--- lzc.sv
`timescale 1ns/1ps
`default_nettype none

module lzc #(
    parameter int WIDTH = 32
) (
    input  wire [WIDTH-1:0]           data_i,
    output logic [$clog2(WIDTH)-1:0]  cnt_o,
    output logic                      empty_o
);
    localparam int CNT_W = $clog2(WIDTH);

    // walk upward so the highest set bit is the last one to write the count
    always_comb begin
        cnt_o = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (data_i[i]) begin
                cnt_o = CNT_W'(WIDTH - 1 - i);
            end
        end
    end

    assign empty_o = ~|data_i;
endmodule

`default_nettype wire

//--- f2i.sv
`timescale 1ns/1ps
`default_nettype none

module f2i #(
    parameter fcvt_pkg::fp_fmt_e FP_FMT = fcvt_pkg::FP32
) (
    fcvt_if.conv cvt_io
);
    localparam int EXP_BITS = fcvt_pkg::exp_bits(FP_FMT);
    localparam int MAN_BITS = fcvt_pkg::man_bits(FP_FMT);
    localparam int BIAS = (1 << (EXP_BITS - 1)) - 1;
    localparam logic [9:0] MAX_SHAMT = 10'(BIAS + MAN_BITS);  // lsb of the mantissa weighs 1 here
    localparam logic [9:0] MAX_INT_EXP = 10'(BIAS + 31);

    logic                sign;
    logic [EXP_BITS-1:0] exp_f;
    logic [MAN_BITS-1:0] man_f;
    logic                exp_nz, exp_all, exp_of;
    logic [9:0]          exp_w;
    logic [MAN_BITS:0]   mant;
    logic                sel_lpath;
    logic [4:0]          lpath_shamt;
    logic [31:0]         lpath_mant;
    logic                lpath_iv, lpath_may_of, lpath_of;
    logic [9:0]          rpath_shamt;
    logic [MAN_BITS+1:0] rpath_shift, rpath_mask, rpath_mag;
    logic                rpath_sticky, rpath_inexact, rpath_cout, rpath_iv;
    logic [MAN_BITS:0]   rpath_round;
    logic                of, iv, ix, iv_sel_max;
    logic [31:0]         int_abs, int_res;

    assign {sign, exp_f, man_f} = cvt_io.src[EXP_BITS+MAN_BITS:0];
    assign exp_nz = |exp_f;
    assign exp_all = &exp_f;
    // subnormals share the exponent of the smallest normal
    assign exp_w = {{(10-EXP_BITS){1'b0}}, exp_f} | {9'd0, ~exp_nz};
    assign mant = {exp_nz, man_f};
    assign exp_of = exp_w > MAX_INT_EXP;
    assign sel_lpath = exp_w >= MAX_SHAMT;

    // large values, integer already, only a left shift
    assign lpath_shamt = 5'(exp_w - MAX_SHAMT);
    assign lpath_mant = {{(31-MAN_BITS){1'b0}}, mant} << lpath_shamt;
    assign lpath_iv = cvt_io.uext & sign;
    assign lpath_may_of = ~cvt_io.uext & (exp_w == MAX_INT_EXP);
    assign lpath_of = lpath_may_of & (~sign | (|man_f));   // only -2^31 itself fits

    assign rpath_shamt = MAX_SHAMT - exp_w;
    assign rpath_shift = {mant, 1'b0} >> rpath_shamt;
    assign rpath_mask = ~({(MAN_BITS+2){1'b1}} << rpath_shamt);
    assign rpath_sticky = |({mant, 1'b0} & rpath_mask);

    fp_rounding #(
        .WIDTH(MAN_BITS + 1)
    ) u_round (
        .mant_i   (rpath_shift[MAN_BITS+1:1]),
        .guard_i  (rpath_shift[0]),
        .sticky_i (rpath_sticky),
        .sign_i   (sign),
        .rm_i     (cvt_io.rm),
        .mant_o   (rpath_round),
        .inexact_o(rpath_inexact),
        .cout_o   (rpath_cout),
        .up_o     ()
    );

    assign rpath_mag = {rpath_cout, rpath_round};
    assign rpath_iv = cvt_io.uext & sign & (|rpath_mag);

    assign of = exp_of | exp_all | (sel_lpath & lpath_of);
    assign iv = of | (sel_lpath ? lpath_iv : rpath_iv);
    assign ix = ~iv & ~sel_lpath & rpath_inexact;
    assign iv_sel_max = cvt_io.is_nan | ~sign;

    assign int_abs = sel_lpath ? lpath_mant : {{(30-MAN_BITS){1'b0}}, rpath_mag};
    assign int_res = (sign & ~cvt_io.uext) ? -int_abs : int_abs;

    always_comb begin
        if (iv) begin
            cvt_io.dest = iv_sel_max ? {cvt_io.uext, {31{1'b1}}} : {~cvt_io.uext, 31'd0};
        end else begin
            cvt_io.dest = int_res;
        end
    end

    assign cvt_io.flags = '{NV: iv, NX: ix, default: 1'b0};
endmodule

`default_nettype wire

//--- i2f.sv
`timescale 1ns/1ps
`default_nettype none

module i2f #(
    parameter fcvt_pkg::fp_fmt_e FP_FMT = fcvt_pkg::FP32
) (
    fcvt_if.conv cvt_io
);
    localparam int EXP_BITS = fcvt_pkg::exp_bits(FP_FMT);
    localparam int MAN_BITS = fcvt_pkg::man_bits(FP_FMT);
    localparam int TOP_EXP = (1 << (EXP_BITS - 1)) - 1 + 31;  // biased exponent of bit 31

    logic                sign;
    logic [31:0]         int_abs, int_norm;
    logic [4:0]          lz_cnt;
    logic                lz_empty;
    logic [EXP_BITS-1:0] raw_exp, exp_o;
    logic [MAN_BITS-1:0] round_mant;
    logic                round_ix, round_cout;

    assign sign = cvt_io.src[31] & ~cvt_io.uext;
    assign int_abs = sign ? -cvt_io.src : cvt_io.src;

    lzc #(
        .WIDTH(32)
    ) u_lzc (
        .data_i (int_abs),
        .cnt_o  (lz_cnt),
        .empty_o(lz_empty)
    );

    assign int_norm = int_abs << lz_cnt;    // leading one lands on bit 31
    assign raw_exp = lz_empty ? '0 : EXP_BITS'(TOP_EXP - lz_cnt);

    // bit 31 is the hidden one and is dropped
    fp_rounding #(
        .WIDTH(MAN_BITS)
    ) u_round (
        .mant_i   (int_norm[30 -: MAN_BITS]),
        .guard_i  (int_norm[30-MAN_BITS]),
        .sticky_i (|int_norm[29-MAN_BITS:0]),
        .sign_i   (sign),
        .rm_i     (cvt_io.rm),
        .mant_o   (round_mant),
        .inexact_o(round_ix),
        .cout_o   (round_cout),
        .up_o     ()
    );

    assign exp_o = raw_exp + EXP_BITS'(round_cout);   // mantissa wrapped to zero on carry
    assign cvt_io.dest = 32'({sign, exp_o, round_mant});
    assign cvt_io.flags = '{NX: round_ix, default: 1'b0};
endmodule

`default_nettype wire

//--- f2f_down.sv
`timescale 1ns/1ps
`default_nettype none

module f2f_down (
    fcvt_if.conv cvt_io
);
    localparam logic [7:0] DELTA = 8'd112;     // 127 - 15
    localparam logic [7:0] MAX_EXP_IN = 8'd142; // maps onto the largest finite fp16 exponent

    fcvt_pkg::fp32_t src;
    logic            exp_nz, exp_all, may_uf, of, uf, rmin, snan;
    logic [7:0]      exp_bias, sub_shift;
    logic [3:0]      sub_shamt;
    logic [9:0]      round_mant, sub_round_mant, of_mant, mant_o;
    logic            round_ix, round_cout, sub_ix, sub_cout, sub_sticky;
    logic [10:0]     sub_mant_pre, sub_mant, sub_mask;
    logic [4:0]      normal_exp, of_exp, exp_o;

    assign src = cvt_io.src;
    assign exp_nz = |src.exp;
    assign exp_all = &src.exp;
    assign snan = cvt_io.is_nan & ~src.mant[22];
    assign may_uf = src.exp <= DELTA;    // fp16 exponent would be zero or below
    assign exp_bias = src.exp - DELTA;

    fp_rounding #(
        .WIDTH(10)
    ) u_round_norm (
        .mant_i   (src.mant[22:13]),
        .guard_i  (src.mant[12]),
        .sticky_i (|src.mant[11:0]),
        .sign_i   (src.sign),
        .rm_i     (cvt_io.rm),
        .mant_o   (round_mant),
        .inexact_o(round_ix),
        .cout_o   (round_cout),
        .up_o     ()
    );

    assign of = (src.exp > MAX_EXP_IN) | ((src.exp == MAX_EXP_IN) & round_cout);
    assign normal_exp = exp_bias[4:0] + 5'(round_cout);

    // everything is shifted out beyond 11 places
    assign sub_shift = DELTA - src.exp;
    assign sub_shamt = (sub_shift > 8'd11) ? 4'd11 : sub_shift[3:0];
    assign sub_mant_pre = {exp_nz, src.mant[22:13]};
    assign sub_mant = sub_mant_pre >> sub_shamt;
    assign sub_mask = ~(11'h7FF << sub_shamt);
    assign sub_sticky = (|src.mant[12:0]) | (|(sub_mant_pre & sub_mask));

    fp_rounding #(
        .WIDTH(10)
    ) u_round_sub (
        .mant_i   (sub_mant[10:1]),
        .guard_i  (sub_mant[0]),
        .sticky_i (sub_sticky),
        .sign_i   (src.sign),
        .rm_i     (cvt_io.rm),
        .mant_o   (sub_round_mant),
        .inexact_o(sub_ix),
        .cout_o   (sub_cout),
        .up_o     ()
    );

    // a carry out of the subnormal path lands on the smallest normal
    assign uf = sub_cout ? (src.exp < DELTA) : may_uf;

    // modes that never round the magnitude up stop at the largest finite value
    assign rmin = (cvt_io.rm == fcvt_pkg::RTZ) ||
                  (cvt_io.rm == fcvt_pkg::RDN && !src.sign) ||
                  (cvt_io.rm == fcvt_pkg::RUP && src.sign);
    assign of_exp = rmin ? 5'd30 : 5'd31;
    assign of_mant = rmin ? 10'h3FF : 10'h000;

    always_comb begin
        if (exp_all) begin
            exp_o = 5'h1F;
            mant_o = {cvt_io.is_nan, 9'd0};    // canonical quiet NaN or infinity
        end else if (of) begin
            exp_o = of_exp;
            mant_o = of_mant;
        end else if (may_uf) begin
            exp_o = {4'd0, sub_cout};
            mant_o = sub_round_mant;
        end else begin
            exp_o = normal_exp;
            mant_o = round_mant;
        end
    end

    assign cvt_io.dest = {16'd0, src.sign & ~cvt_io.is_nan, exp_o, mant_o};

    assign cvt_io.flags.NV = snan;
    assign cvt_io.flags.DZ = 1'b0;
    assign cvt_io.flags.OF = ~exp_all & of;
    assign cvt_io.flags.UF = ~exp_all & uf & sub_ix;
    assign cvt_io.flags.NX = ~exp_all & (of | (may_uf ? sub_ix : round_ix));
endmodule

`default_nettype wire

//--- fcvt_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fcvt_unit (
    input  wire                       clk_i,
    input  wire                       rst_n_i,
    input  wire                       req_valid_i,
    output logic                      req_ready_o,
    input  wire fcvt_pkg::fcvt_op_e   req_op_i,
    input  wire [31:0]                req_src_i,
    input  wire fcvt_pkg::roundmode_e req_rm_i,
    input  wire                       req_uext_i,
    output logic                      res_valid_o,
    input  wire                       res_ready_i,
    output logic [31:0]               res_data_o,
    output fcvt_pkg::fflags_t         res_flags_o
);
    fcvt_pkg::fp_word_u src_w;
    logic               is_nan;
    logic               req_fire;
    logic [31:0]        res_d;
    fcvt_pkg::fflags_t  flags_d;

    fcvt_if cvt_f2i ();
    fcvt_if cvt_i2f ();
    fcvt_if cvt_f2h ();

    assign src_w.raw = req_src_i;
    assign is_nan = (&src_w.fp.exp) & (|src_w.fp.mant);   // classified once for both float paths

    assign cvt_f2i.src = src_w.fp;
    assign cvt_f2i.rm = req_rm_i;
    assign cvt_f2i.uext = req_uext_i;
    assign cvt_f2i.is_nan = is_nan;

    assign cvt_i2f.src = src_w.raw;
    assign cvt_i2f.rm = req_rm_i;
    assign cvt_i2f.uext = req_uext_i;
    assign cvt_i2f.is_nan = is_nan;

    assign cvt_f2h.src = src_w.fp;
    assign cvt_f2h.rm = req_rm_i;
    assign cvt_f2h.uext = req_uext_i;
    assign cvt_f2h.is_nan = is_nan;

    f2i #(.FP_FMT(fcvt_pkg::FP32)) u_f2i (.cvt_io(cvt_f2i));

    i2f #(.FP_FMT(fcvt_pkg::FP32)) u_i2f (.cvt_io(cvt_i2f));

    f2f_down u_f2h (.cvt_io(cvt_f2h));

    always_comb begin
        case (req_op_i)
            fcvt_pkg::OP_I2F: begin
                res_d = cvt_i2f.dest;
                flags_d = cvt_i2f.flags;
            end
            fcvt_pkg::OP_F2H: begin
                res_d = cvt_f2h.dest;
                flags_d = cvt_f2h.flags;
            end
            default: begin
                res_d = cvt_f2i.dest;
                flags_d = cvt_f2i.flags;
            end
        endcase
    end

    // a new request may enter when the slot is empty or is drained this cycle
    assign req_ready_o = ~res_valid_o | res_ready_i;
    assign req_fire = req_valid_i & req_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            res_valid_o <= 1'b0;
        end else if (req_ready_o) begin
            res_valid_o <= req_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            res_data_o <= res_d;
            res_flags_o <= flags_d;
        end
    end
endmodule

`default_nettype wire

//--- fcvt_chk.sv
`timescale 1ns/1ps
`default_nettype none

module fcvt_chk (
    input wire                       clk_i,
    input wire                       rst_n_i,
    input wire                       req_valid_i,
    input wire                       req_ready_o,
    input wire fcvt_pkg::fcvt_op_e   req_op_i,
    input wire [31:0]                req_src_i,
    input wire fcvt_pkg::roundmode_e req_rm_i,
    input wire                       req_uext_i,
    input wire                       res_valid_o,
    input wire                       res_ready_i,
    input wire [31:0]                res_data_o,
    input wire fcvt_pkg::fflags_t    res_flags_o
);
    int unsigned        fail_cnt = 0;
    fcvt_pkg::fp32_t    f;
    fcvt_pkg::fflags_t  want_flags, want_flags_q;
    fcvt_pkg::fcvt_op_e op_q;
    logic [31:0]        mag, twice, want, want_q;
    logic [23:0]        sig;
    logic               f_nan, half, top_fits, f2i_inv, hit, hit_q, rne, rtz_pos;

    function automatic logic [31:0] int_to_fp(input logic sign, input logic [31:0] m);
        int          p;
        logic [31:0] norm;
        if (m == 32'd0) begin
            return 32'd0;
        end
        p = 23;
        while (p > 0 && !m[p]) begin
            p--;
        end
        norm = m << (23 - p);   // leading one sits on bit 23 and is hidden
        return {sign, 8'(127 + p), norm[22:0]};
    endfunction

    // rounds k + 0.5 to an integer and then applies the sign
    function automatic logic [31:0] round_half(input logic sign, input logic [31:0] k,
                                               input fcvt_pkg::roundmode_e rm);
        logic [31:0] m;
        case (rm)
            fcvt_pkg::RNE: m = k + 32'(k[0]);
            fcvt_pkg::RTZ: m = k;
            fcvt_pkg::RDN: m = k + {31'd0, sign};
            fcvt_pkg::RUP: m = k + {31'd0, ~sign};
            default:       m = k + 32'd1;
        endcase
        return sign ? -m : m;
    endfunction

    assign f = req_src_i;
    assign f_nan = (&f.exp) & (|f.mant);
    assign mag = (req_src_i[31] & ~req_uext_i) ? -req_src_i : req_src_i;
    assign sig = {1'b1, f.mant};
    assign twice = 32'(sig) >> (8'd149 - f.exp);   // an odd integer when the input is k + 0.5
    assign half = (f.exp >= 8'd126) && (f.exp <= 8'd149) && twice[0] &&
                  ((twice << (8'd149 - f.exp)) == 32'(sig));
    // exponent 158 still fits when it is -2^31 signed or any positive value unsigned
    assign top_fits = (f.exp == 8'd158) &
                      (req_uext_i ? ~f.sign : (f.sign & (f.mant == 23'd0)));
    assign f2i_inv = f_nan | ((f.exp >= 8'd158) & ~top_fits) |
                     (req_uext_i & f.sign & (f.exp >= 8'd127));
    assign rne = req_rm_i == fcvt_pkg::RNE;
    assign rtz_pos = (req_rm_i == fcvt_pkg::RTZ) & ~f.sign;

    always_comb begin
        hit = 1'b0;
        want = 32'd0;
        want_flags = '0;
        case (req_op_i)
            fcvt_pkg::OP_I2F: begin
                if (mag < 32'h0100_0000) begin
                    hit = 1'b1;
                    want = int_to_fp(req_src_i[31] & ~req_uext_i, mag);
                end
            end
            fcvt_pkg::OP_F2I: begin
                if (f2i_inv) begin
                    hit = 1'b1;
                    if (f_nan || !f.sign) begin
                        want = req_uext_i ? 32'hFFFF_FFFF : 32'h7FFF_FFFF;
                    end else begin
                        want = req_uext_i ? 32'h0000_0000 : 32'h8000_0000;
                    end
                    want_flags.NV = 1'b1;
                end else if (half && !(req_uext_i && f.sign)) begin
                    hit = 1'b1;
                    want = round_half(f.sign, twice >> 1, req_rm_i);
                    want_flags.NX = 1'b1;
                end
            end
            fcvt_pkg::OP_F2H: begin
                if (f_nan) begin
                    hit = 1'b1;
                    want = 32'h0000_7E00;
                    want_flags.NV = ~f.mant[22];   // quiet bit clear means signalling
                end else if (f.exp > 8'd142 && f.exp != 8'hFF && (rne || rtz_pos)) begin
                    hit = 1'b1;
                    want = rne ? {16'd0, f.sign, 15'h7C00} : 32'h0000_7BFF;
                    want_flags.OF = 1'b1;
                    want_flags.NX = 1'b1;
                end else if (f.exp >= 8'd113 && f.exp <= 8'd142 && f.mant[12:0] == 13'd0) begin
                    hit = 1'b1;
                    want = {16'd0, f.sign, 5'(f.exp - 8'd127 + 8'd15), f.mant[22:13]};
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            hit_q <= hit;
            want_q <= want;
            want_flags_q <= want_flags;
            op_q <= req_op_i;
        end
    end

    after_reset: assert property (@(posedge clk_i) !rst_n_i |=> !res_valid_o)
        else begin
            fail_cnt++;
            $error("res_valid_o was high in the cycle after reset");
        end

    result_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_valid_i && req_ready_o |=> res_valid_o)
        else begin
            fail_cnt++;
            $error("an accepted request did not show a result one cycle later");
        end

    hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        res_valid_o && !res_ready_i |=> $stable(res_data_o) && $stable(res_flags_o))
        else begin
            fail_cnt++;
            $error("the held result changed while res_ready_i was low");
        end

    hold_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        res_valid_o && !res_ready_i |-> !req_ready_o)
        else begin
            fail_cnt++;
            $error("req_ready_o was high while a result was stalled");
        end

    result_value: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        res_valid_o && hit_q |-> res_data_o == want_q && res_flags_o == want_flags_q)
        else begin
            fail_cnt++;
            $error("mismatch at %0t: op %0d gave %h flags %b, expected %h flags %b", $time,
                   $sampled(op_q), $sampled(res_data_o), $sampled(res_flags_o),
                   $sampled(want_q), $sampled(want_flags_q));
        end
endmodule

bind fcvt_unit fcvt_chk u_chk (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .req_valid_i(req_valid_i), .req_ready_o(req_ready_o),
    .req_op_i(req_op_i), .req_src_i(req_src_i),
    .req_rm_i(req_rm_i), .req_uext_i(req_uext_i),
    .res_valid_o(res_valid_o), .res_ready_i(res_ready_i),
    .res_data_o(res_data_o), .res_flags_o(res_flags_o)
);

`default_nettype wire

//--- tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD = 10,
    parameter int RST_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_n_o
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // reset is released on a rising edge, like any other synchronous input
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end
endmodule

`default_nettype wire

//--- tb_fcvt.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fcvt;
    localparam int N_HS = 40;
    localparam int N_I2F = 60;
    localparam int N_HALF = 60;
    localparam int N_INV = 40;
    localparam int N_F2H = 60;
    // a request takes a handful of cycles at worst under random stalls
    localparam int WATCHDOG_CYCLES = 8 + 6 * (N_HS + N_I2F + N_HALF + N_INV + N_F2H) + 400;

    logic                 clk_i, rst_n_i;
    logic                 req_valid_i, req_ready_o, req_uext_i;
    fcvt_pkg::fcvt_op_e   req_op_i;
    logic [31:0]          req_src_i;
    fcvt_pkg::roundmode_e req_rm_i;
    logic                 res_valid_o, res_ready_i;
    logic [31:0]          res_data_o;
    fcvt_pkg::fflags_t    res_flags_o;
    logic [31:0]          lfsr_q = 32'h4e98c745;
    int unsigned          tests_run = 0;
    int unsigned          tests_failed = 0;
    int unsigned          fails_seen = 0;

    tb_clk_gen #(.PERIOD(10), .RST_CYCLES(8)) u_clk (.clk_o(clk_i), .rst_n_o(rst_n_i));

    fcvt_unit dut_i (.*);

    // fibonacci lfsr with taps 32 22 2 1 that steps once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic fcvt_pkg::roundmode_e pick_rm();
        return fcvt_pkg::roundmode_e'(3'(rand_bits(3) % 5));
    endfunction

    // fp32 that holds exactly k + 0.5 for any k below 2^23
    function automatic logic [31:0] half_float(input logic sign, input logic [31:0] k);
        int          p;
        logic [31:0] odd, norm;
        odd = (k << 1) | 32'd1;
        p = 23;
        while (p > 0 && !odd[p]) begin
            p--;
        end
        norm = odd << (23 - p);
        return {sign, 8'(126 + p), norm[22:0]};
    endfunction

    task automatic send(input fcvt_pkg::fcvt_op_e op, input logic [31:0] src,
                        input fcvt_pkg::roundmode_e rm, input logic uext);
        req_valid_i <= 1'b1;
        req_op_i <= op;
        req_src_i <= src;
        req_rm_i <= rm;
        req_uext_i <= uext;
        @(negedge clk_i);
        while (!req_ready_o) begin
            @(posedge clk_i);
            res_ready_i <= rand_bits(2) != 0;
            @(negedge clk_i);
        end
        @(posedge clk_i);
        res_ready_i <= rand_bits(2) != 0;
    endtask

    task automatic finish_test(input string name);
        int unsigned errs;
        req_valid_i <= 1'b0;
        res_ready_i <= 1'b1;
        @(negedge clk_i);
        while (res_valid_o) @(negedge clk_i);
        @(negedge clk_i);
        errs = dut_i.u_chk.fail_cnt - fails_seen;
        fails_seen = dut_i.u_chk.fail_cnt;
        tests_run++;
        if (errs == 0) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d assertion errors", name, errs);
        end
        @(posedge clk_i);
    endtask

    initial begin
        logic [31:0] m;
        logic        s, u;
        req_valid_i = 1'b0;
        req_op_i = fcvt_pkg::OP_F2I;
        req_src_i = 32'd0;
        req_rm_i = fcvt_pkg::RNE;
        req_uext_i = 1'b0;
        res_ready_i = 1'b0;
        wait (rst_n_i === 1'b1);
        @(posedge clk_i);

        for (int i = 0; i < N_HS; i++) begin
            send(fcvt_pkg::fcvt_op_e'(2'(rand_bits(2) % 3)), rand_bits(32), pick_rm(),
                 1'(rand_bits(1)));
        end
        finish_test("handshake");

        for (int i = 0; i < N_I2F; i++) begin
            m = (i == 0) ? 32'd0 : rand_bits(24);
            u = 1'(rand_bits(1));
            s = ~u & 1'(rand_bits(1));
            send(fcvt_pkg::OP_I2F, s ? -m : m, pick_rm(), u);
        end
        finish_test("i2f_exact");

        for (int i = 0; i < N_HALF; i++) begin
            m = rand_bits((i % 2 == 1) ? 22 : 3);   // small k hits both parities often
            send(fcvt_pkg::OP_F2I, half_float(1'(rand_bits(1)), m),
                 fcvt_pkg::roundmode_e'(3'(i % 5)), 1'b0);
        end
        finish_test("f2i_round_half");

        for (int i = 0; i < N_INV; i++) begin
            s = 1'(rand_bits(1));
            u = 1'(rand_bits(1));
            m = rand_bits(23);
            case (i % 4)
                0: send(fcvt_pkg::OP_F2I, {s, 8'hFF, m[22:0] | 23'd1}, pick_rm(), u);
                1: send(fcvt_pkg::OP_F2I, {s, 8'(158 + rand_bits(7) % 97), m[22:0]}, pick_rm(),
                        u);
                2: send(fcvt_pkg::OP_F2I, {1'b1, 8'(127 + rand_bits(5)), m[22:0]}, pick_rm(), 1'b1);
                default: send(fcvt_pkg::OP_F2I, {s, 8'hFF, 23'd0}, pick_rm(), u);
            endcase
        end
        finish_test("f2i_invalid");

        for (int i = 0; i < N_F2H; i++) begin
            s = 1'(rand_bits(1));
            m = rand_bits(23);
            case (i % 4)
                0: send(fcvt_pkg::OP_F2H, {s, 8'hFF, m[22:0] | 23'd1}, pick_rm(), 1'b0);
                1: send(fcvt_pkg::OP_F2H, {s, 8'(143 + rand_bits(7) % 112), m[22:0]},
                        fcvt_pkg::RNE, 1'b0);
                2: send(fcvt_pkg::OP_F2H, {1'b0, 8'(143 + rand_bits(7) % 112), m[22:0]},
                        fcvt_pkg::RTZ, 1'b0);
                default: send(fcvt_pkg::OP_F2H, {s, 8'(113 + rand_bits(5) % 30), m[22:13], 13'd0},
                              pick_rm(), 1'b0);
            endcase
        end
        finish_test("f2h_special");

        $display("%0d tests run, %0d failed, %0d assertion errors", tests_run, tests_failed,
                 dut_i.u_chk.fail_cnt);
        if (tests_failed == 0 && dut_i.u_chk.fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("timeout: the tests did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end
endmodule

`default_nettype wire

//--- compile.f
fcvt_pkg.sv
fcvt_if.sv
fp_rounding.sv
lzc.sv
f2i.sv
i2f.sv
f2f_down.sv
fcvt_unit.sv
fcvt_chk.sv
tb_clk_gen.sv
tb_fcvt.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log for the verdict
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_fcvt -f compile.f -o Vtb_fcvt

# the verdict comes from the log, so a non-zero exit here must not stop the script
./obj_dir/Vtb_fcvt +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
else
    exit 1
fi
